// File: hdl/forth_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types and constants for the serial Forth machine
// Imported by every RTL unit that needs cell, address or opcode types
// ROM layout constants must agree with the boot ROM image
//////////////////////////////////////////////////////////////////////

package forth_pkg;

	// Data stack cell and ROM word
	typedef logic [31:0] cell_t;
	// ROM address, 128 cells
	typedef logic [6:0] addr_t;
	// Serial character
	typedef logic [7:0] char_t;

	// Kept short for simulation
	localparam int CLKS_PER_BIT = 16;
	typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;

	// Circular data stack
	localparam int STACK_DEPTH = 16;
	typedef logic [$clog2(STACK_DEPTH)-1:0] sp_t;

	// XT and number queues in the outer interpreter
	localparam int QUEUE_DEPTH = 8;
	typedef logic [$clog2(QUEUE_DEPTH)-1:0] qptr_t;
	typedef logic [$clog2(QUEUE_DEPTH):0] qcnt_t;

	// ROM layout
	localparam addr_t DICT_START = 7'd64;
	localparam addr_t XT_ERROR = 7'd1;
	localparam addr_t XT_NUMBER = 7'd6;

	// Opcodes, execute must stay at zero (reset PC points at it)
	typedef enum logic [15:0] {
		OP_EXECUTE,
		OP_LIT,
		OP_PLUS,
		OP_MINUS,
		OP_DUP,
		OP_DROP,
		OP_NEGATE,
		OP_ZERO_EQUAL,
		OP_ZERO_LESS_THAN,
		OP_BRANCH,
		OP_0BRANCH,
		OP_EMIT,
		OP_IO_LED,
		OP_NUMBER
	} op_e;

endpackage

// File: hdl/uart_rx.sv
//////////////////////////////////////////////////////////////////////
// UART receiver, 8N1, LSB first, sampled at mid-bit
// Holds one byte with rx_valid until the consumer pulses rx_take
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_rx
	import forth_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  rx,
	input  logic  rx_take,
	output logic  rx_valid,
	output char_t rx_data
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	rx_state_e  state;
	baud_cnt_t  baud_cnt;
	logic [2:0] bit_idx;
	char_t      shifter;
	logic       bit_done;

	// Full bit period elapsed
	assign bit_done = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= RX_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			shifter <= '0;
			rx_valid <= 1'b0;
			rx_data <= '0;
		end else begin
			if (rx_take) begin
				rx_valid <= 1'b0;
			end
			baud_cnt <= baud_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					if (!rx) begin
						state <= RX_START;
					end
				end
				// Half a bit in, recheck start bit
				RX_START: begin
					if (baud_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1)) begin
						baud_cnt <= '0;
						bit_idx <= '0;
						state <= rx ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (bit_done) begin
						shifter <= {rx, shifter[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end
					end
				end
				// Byte dropped if previous one still held
				RX_STOP: begin
					if (bit_done) begin
						state <= RX_IDLE;
						if (rx && !rx_valid) begin
							rx_valid <= 1'b1;
							rx_data <= shifter;
						end
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Consumer takes only a held byte
	assert property (@(posedge clk) disable iff (!reset) rx_take |-> rx_valid);

endmodule

// File: hdl/uart_tx.sv
//////////////////////////////////////////////////////////////////////
// UART transmitter, 8N1, LSB first
// One byte per tx_send pulse, tx_busy high for the whole frame
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_tx
	import forth_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  tx_send,
	input  char_t tx_data,
	output logic  tx,
	output logic  tx_busy
);

	baud_cnt_t  baud_cnt;
	logic [3:0] bit_cnt;
	// Data bits followed by the stop bit
	logic [8:0] shifter;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			tx <= 1'b1;
			tx_busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
			shifter <= '1;
		end else if (tx_send) begin
			// Start bit goes out right away
			tx <= 1'b0;
			tx_busy <= 1'b1;
			shifter <= {1'b1, tx_data};
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else if (tx_busy) begin
			baud_cnt <= baud_cnt + 1'b1;
			if (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) begin
				baud_cnt <= '0;
				if (bit_cnt == 4'd9) begin
					// End of stop bit
					tx_busy <= 1'b0;
				end else begin
					tx <= shifter[0];
					shifter <= {1'b1, shifter[8:1]};
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// Inner interpreter waits out each frame before the next emit
	assert property (@(posedge clk) disable iff (!reset) tx_send |-> !tx_busy);

endmodule

// File: hdl/boot_rom.sv
//////////////////////////////////////////////////////////////////////
// Boot ROM with the code routines and the word dictionary
// Port A serves the dictionary search, port B the instruction fetch
// Dictionary entry is link, name cell {len, c1, c2, c3}, XT
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module boot_rom
	import forth_pkg::*;
(
	input  addr_t addr_a,
	output cell_t data_a,
	input  addr_t addr_b,
	output cell_t data_b
);

	localparam cell_t IMAGE [128] = '{
		// Dispatcher, every routine branches back here
		0: cell_t'(OP_EXECUTE),
		// Unknown word reply
		1: cell_t'(OP_LIT), 2: "?", 3: cell_t'(OP_EMIT),
		4: cell_t'(OP_BRANCH), 5: 0,
		// Number push
		6: cell_t'(OP_NUMBER), 7: cell_t'(OP_BRANCH), 8: 0,
		// led
		9: cell_t'(OP_IO_LED), 10: cell_t'(OP_BRANCH), 11: 0,
		// + and -
		12: cell_t'(OP_PLUS), 13: cell_t'(OP_BRANCH), 14: 0,
		15: cell_t'(OP_MINUS), 16: cell_t'(OP_BRANCH), 17: 0,
		// dup, drp, neg
		18: cell_t'(OP_DUP), 19: cell_t'(OP_BRANCH), 20: 0,
		21: cell_t'(OP_DROP), 22: cell_t'(OP_BRANCH), 23: 0,
		24: cell_t'(OP_NEGATE), 25: cell_t'(OP_BRANCH), 26: 0,
		// 0= and emt
		27: cell_t'(OP_ZERO_EQUAL), 28: cell_t'(OP_BRANCH), 29: 0,
		30: cell_t'(OP_EMIT), 31: cell_t'(OP_BRANCH), 32: 0,
		// Dot, sign check first
		33: cell_t'(OP_DUP), 34: cell_t'(OP_ZERO_LESS_THAN),
		35: cell_t'(OP_0BRANCH), 36: 41,
		37: cell_t'(OP_LIT), 38: "-", 39: cell_t'(OP_EMIT), 40: cell_t'(OP_NEGATE),
		// Single digit then trailing space
		41: cell_t'(OP_LIT), 42: "0", 43: cell_t'(OP_PLUS), 44: cell_t'(OP_EMIT),
		45: cell_t'(OP_LIT), 46: " ", 47: cell_t'(OP_EMIT),
		48: cell_t'(OP_BRANCH), 49: 0,
		// Dictionary chain starting at DICT_START
		64: 67, 65: {8'd1, "+", 16'h0}, 66: 12,
		67: 70, 68: {8'd1, "-", 16'h0}, 69: 15,
		70: 73, 71: {8'd3, "dup"}, 72: 18,
		73: 76, 74: {8'd3, "drp"}, 75: 21,
		76: 79, 77: {8'd3, "neg"}, 78: 24,
		79: 82, 80: {8'd2, "0=", 8'h0}, 81: 27,
		82: 85, 83: {8'd1, ".", 16'h0}, 84: 33,
		85: 88, 86: {8'd3, "emt"}, 87: 30,
		// Last entry, zero link
		88: 0, 89: {8'd3, "led"}, 90: 9,
		default: '0
	};

	assign data_a = IMAGE[addr_a];
	assign data_b = IMAGE[addr_b];

endmodule

// File: hdl/outer_interp.sv
//////////////////////////////////////////////////////////////////////
// Outer interpreter, splits input on spaces and resolves each token
// Dictionary hit, decimal number or error XT goes to the XT queue
// On CR or LF the queue is handed to the inner interpreter
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module outer_interp
	import forth_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  rx_valid,
	input  char_t rx_data,
	output logic  rx_take,
	output addr_t dict_addr,
	input  cell_t dict_data,
	input  logic  xt_pop,
	output logic  xt_valid,
	output addr_t xt,
	input  logic  num_pop,
	output cell_t num_data
);

	typedef enum logic [2:0] {IDLE, PARSE, GET_LINK, CHECK_NAME, GET_XT, EXECUTE} state_e;

	state_e      state;
	char_t       ch;
	char_t       tok_len;
	logic [23:0] name_chars;
	cell_t       name_key;
	cell_t       value;
	logic        all_digits;
	logic        line_end;
	addr_t       entry;
	addr_t       link;
	logic        is_space;
	logic        is_eol;
	logic        is_digit;
	logic        push_xt;
	logic        push_num;
	addr_t       xt_in;
	addr_t       xt_mem [QUEUE_DEPTH];
	cell_t       num_mem [QUEUE_DEPTH];
	qptr_t       xt_wr;
	qptr_t       xt_rd;
	qptr_t       num_wr;
	qptr_t       num_rd;
	qcnt_t       xt_cnt;
	qcnt_t       num_cnt;

	// Character classes, LF and CR both end a line
	assign is_space = (ch == 8'h20);
	assign is_eol = (ch == 8'h0a) || (ch == 8'h0d);
	assign is_digit = (ch >= 8'h30) && (ch <= 8'h39);
	// Same layout as a dictionary name cell
	assign name_key = {tok_len, name_chars};

	assign rx_take = (state == IDLE) && rx_valid;
	assign xt_valid = (state == EXECUTE) && (xt_cnt != '0);
	assign xt = xt_mem[xt_rd];
	assign num_data = num_mem[num_rd];

	////////////////////////////////////////////////////////////////////
	// Dictionary walk and token resolution
	////////////////////////////////////////////////////////////////////
	always_comb begin
		dict_addr = entry;
		push_xt = 1'b0;
		push_num = 1'b0;
		xt_in = XT_ERROR;
		case (state)
			CHECK_NAME: begin
				dict_addr = entry + addr_t'(1);
				// End of chain without a match
				if (dict_data != name_key && link == '0) begin
					push_xt = 1'b1;
					push_num = all_digits;
					xt_in = all_digits ? XT_NUMBER : XT_ERROR;
				end
			end
			GET_XT: begin
				dict_addr = entry + addr_t'(2);
				push_xt = 1'b1;
				xt_in = addr_t'(dict_data);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= IDLE;
			ch <= '0;
			tok_len <= '0;
			name_chars <= '0;
			value <= '0;
			all_digits <= 1'b1;
			line_end <= 1'b0;
			entry <= DICT_START;
			link <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (rx_valid) begin
						ch <= rx_data;
						state <= PARSE;
					end
				end
				PARSE: begin
					if (is_space || is_eol) begin
						line_end <= is_eol;
						entry <= DICT_START;
						// Empty token queues nothing
						if (tok_len != '0) begin
							state <= GET_LINK;
						end else begin
							state <= is_eol ? EXECUTE : IDLE;
						end
					end else begin
						// Length saturates, long names never match
						if (tok_len != '1) begin
							tok_len <= tok_len + 1'b1;
						end
						case (tok_len)
							8'd0: name_chars[23:16] <= ch;
							8'd1: name_chars[15:8] <= ch;
							8'd2: name_chars[7:0] <= ch;
							default: ;
						endcase
						value <= value * 32'd10 + cell_t'(ch - 8'h30);
						all_digits <= all_digits && is_digit;
						state <= IDLE;
					end
				end
				GET_LINK: begin
					link <= addr_t'(dict_data);
					state <= CHECK_NAME;
				end
				CHECK_NAME: begin
					if (dict_data == name_key) begin
						state <= GET_XT;
					end else if (link != '0) begin
						entry <= link;
						state <= GET_LINK;
					end
				end
				// Line done once every XT is taken
				EXECUTE: begin
					if (xt_cnt == '0) begin
						state <= IDLE;
					end
				end
				default: ;
			endcase
			// Token resolved, start the next one
			if (push_xt) begin
				tok_len <= '0;
				name_chars <= '0;
				value <= '0;
				all_digits <= 1'b1;
				state <= line_end ? EXECUTE : IDLE;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// XT and number queues
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			xt_wr <= '0;
			xt_rd <= '0;
			xt_cnt <= '0;
			num_wr <= '0;
			num_rd <= '0;
			num_cnt <= '0;
		end else begin
			xt_wr <= xt_wr + qptr_t'(push_xt);
			xt_rd <= xt_rd + qptr_t'(xt_pop);
			xt_cnt <= xt_cnt + qcnt_t'(push_xt) - qcnt_t'(xt_pop);
			num_wr <= num_wr + qptr_t'(push_num);
			num_rd <= num_rd + qptr_t'(num_pop);
			num_cnt <= num_cnt + qcnt_t'(push_num) - qcnt_t'(num_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push_xt) begin
			xt_mem[xt_wr] <= xt_in;
		end
		if (push_num) begin
			num_mem[num_wr] <= value;
		end
	end

	// A line holds at most QUEUE_DEPTH tokens
	assert property (@(posedge clk) disable iff (!reset)
		push_xt |-> (xt_cnt < QUEUE_DEPTH) && (!push_num || num_cnt < QUEUE_DEPTH));

endmodule

// File: hdl/inner_interp.sv
//////////////////////////////////////////////////////////////////////
// Inner interpreter, fetch and execute over the boot ROM code
// Runs queued XTs from the outer interpreter on a circular stack
// Drives the UART transmitter and the three active-low LEDs
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module inner_interp
	import forth_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  cell_t code_data,
	output addr_t pc,
	input  logic  xt_valid,
	input  addr_t xt,
	output logic  xt_pop,
	input  cell_t num_data,
	output logic  num_pop,
	output logic  tx_send,
	output char_t tx_data,
	input  logic  tx_busy,
	output logic  led_r,
	output logic  led_g,
	output logic  led_b
);

	typedef enum logic [1:0] {RUN, OPERAND, EMIT_WAIT} state_e;

	state_e state;
	state_e state_n;
	op_e    op;
	op_e    pending;
	op_e    pending_n;
	addr_t  pc_n;
	sp_t    sp;
	sp_t    sp_n;
	sp_t    sp_up;
	sp_t    sp_dn;
	cell_t  stack [STACK_DEPTH];
	cell_t  tos;
	cell_t  nos;
	logic   we;
	sp_t    wa;
	cell_t  wd;
	logic   led_we;

	assign op = op_e'(code_data[15:0]);
	// Pointer wraps, stack is circular
	assign sp_up = sp + sp_t'(1);
	assign sp_dn = sp - sp_t'(1);
	assign tos = stack[sp];
	assign nos = stack[sp_dn];
	assign tx_data = tos[7:0];

	////////////////////////////////////////////////////////////////////
	// Decode and next state
	////////////////////////////////////////////////////////////////////
	always_comb begin
		state_n = state;
		pending_n = pending;
		pc_n = pc;
		sp_n = sp;
		we = 1'b0;
		wa = sp;
		wd = tos;
		xt_pop = 1'b0;
		num_pop = 1'b0;
		tx_send = 1'b0;
		led_we = 1'b0;
		case (state)
			RUN: begin
				pc_n = pc + addr_t'(1);
				we = op inside {OP_PLUS, OP_MINUS, OP_DUP, OP_NEGATE, OP_ZERO_EQUAL,
					OP_ZERO_LESS_THAN, OP_NUMBER};
				case (op)
					// Stall until the line is ready
					OP_EXECUTE: begin
						pc_n = xt_valid ? xt : pc;
						xt_pop = xt_valid;
					end
					OP_LIT, OP_BRANCH, OP_0BRANCH: begin
						pending_n = op;
						state_n = OPERAND;
					end
					OP_PLUS: begin
						wa = sp_dn;
						wd = nos + tos;
						sp_n = sp_dn;
					end
					OP_MINUS: begin
						wa = sp_dn;
						wd = nos - tos;
						sp_n = sp_dn;
					end
					OP_DUP: begin
						wa = sp_up;
						sp_n = sp_up;
					end
					OP_DROP: sp_n = sp_dn;
					OP_NEGATE: wd = '0 - tos;
					// Flags are all ones for true
					OP_ZERO_EQUAL: wd = {32{tos == '0}};
					OP_ZERO_LESS_THAN: wd = {32{tos[31]}};
					OP_EMIT: begin
						tx_send = 1'b1;
						sp_n = sp_dn;
						state_n = EMIT_WAIT;
					end
					OP_IO_LED: begin
						led_we = 1'b1;
						sp_n = sp_dn;
					end
					OP_NUMBER: begin
						num_pop = 1'b1;
						wa = sp_up;
						wd = num_data;
						sp_n = sp_up;
					end
					default: ;
				endcase
			end
			// Operand cell of lit and the branches
			OPERAND: begin
				state_n = RUN;
				pc_n = pc + addr_t'(1);
				case (pending)
					OP_LIT: begin
						we = 1'b1;
						wa = sp_up;
						wd = code_data;
						sp_n = sp_up;
					end
					OP_BRANCH: pc_n = addr_t'(code_data);
					OP_0BRANCH: begin
						sp_n = sp_dn;
						if (tos == '0) begin
							pc_n = addr_t'(code_data);
						end
					end
					default: ;
				endcase
			end
			EMIT_WAIT: begin
				if (!tx_busy) begin
					state_n = RUN;
				end
			end
			default: state_n = RUN;
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= RUN;
			pending <= OP_EXECUTE;
			pc <= '0;
			sp <= '0;
			led_r <= 1'b1;
			led_g <= 1'b1;
			led_b <= 1'b1;
		end else begin
			state <= state_n;
			pending <= pending_n;
			pc <= pc_n;
			sp <= sp_n;
			// LED on when its bit is set
			if (led_we) begin
				led_g <= ~tos[0];
				led_b <= ~tos[1];
				led_r <= ~tos[2];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			stack[wa] <= wd;
		end
	end

	// ROM code only holds known opcodes where one is fetched
	assert property (@(posedge clk) disable iff (!reset)
		(state == RUN) |-> (code_data <= cell_t'(op.last())));

endmodule

// File: hdl/forth_core.sv
//////////////////////////////////////////////////////////////////////
// Forth machine top level
// Serial in, serial out and three active-low LEDs
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module forth_core
	import forth_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic tx,
	output logic led_r,
	output logic led_g,
	output logic led_b
);

	// Receiver to outer interpreter
	logic  rx_valid;
	char_t rx_data;
	logic  rx_take;
	// ROM ports
	addr_t dict_addr;
	cell_t dict_data;
	addr_t pc;
	cell_t code_data;
	// Queues between the interpreters
	logic  xt_valid;
	addr_t xt;
	logic  xt_pop;
	cell_t num_data;
	logic  num_pop;
	// Inner interpreter to transmitter
	logic  tx_send;
	char_t tx_data;
	logic  tx_busy;

	uart_rx uart_rx_inst (
		.clk      (clk),
		.reset    (reset),
		.rx       (rx),
		.rx_take  (rx_take),
		.rx_valid (rx_valid),
		.rx_data  (rx_data)
	);

	uart_tx uart_tx_inst (
		.clk     (clk),
		.reset   (reset),
		.tx_send (tx_send),
		.tx_data (tx_data),
		.tx      (tx),
		.tx_busy (tx_busy)
	);

	boot_rom boot_rom_inst (
		.addr_a (dict_addr),
		.data_a (dict_data),
		.addr_b (pc),
		.data_b (code_data)
	);

	outer_interp outer_interp_inst (
		.clk       (clk),
		.reset     (reset),
		.rx_valid  (rx_valid),
		.rx_data   (rx_data),
		.rx_take   (rx_take),
		.dict_addr (dict_addr),
		.dict_data (dict_data),
		.xt_pop    (xt_pop),
		.xt_valid  (xt_valid),
		.xt        (xt),
		.num_pop   (num_pop),
		.num_data  (num_data)
	);

	inner_interp inner_interp_inst (
		.clk       (clk),
		.reset     (reset),
		.code_data (code_data),
		.pc        (pc),
		.xt_valid  (xt_valid),
		.xt        (xt),
		.xt_pop    (xt_pop),
		.num_data  (num_data),
		.num_pop   (num_pop),
		.tx_send   (tx_send),
		.tx_data   (tx_data),
		.tx_busy   (tx_busy),
		.led_r     (led_r),
		.led_g     (led_g),
		.led_b     (led_b)
	);

endmodule

// File: tests/forth_core_tb.sv
//////////////////////////////////////////////////////////////////////
// Self-checking testbench for the serial Forth machine
// Replays input lines from the vector file over rx and decodes tx
// Each record gives the printed text and the LED state after the line
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module forth_core_tb
	import forth_pkg::*;
;

	logic clk;
	logic reset;
	logic rx;
	logic tx;
	logic led_r;
	logic led_g;
	logic led_b;

	// Flattened vector storage
	logic [7:0] in_buf [1024];
	logic [7:0] out_buf [1024];
	int         in_start [64];
	int         in_len [64];
	int         out_start [64];
	int         out_len [64];
	logic [2:0] led_exp [64];
	int         num_records = 0;

	// Run bookkeeping
	int error_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	forth_core forth_core_inst (
		.clk   (clk),
		.reset (reset),
		.rx    (rx),
		.tx    (tx),
		.led_r (led_r),
		.led_g (led_g),
		.led_b (led_b)
	);

	// 20 ns clock
	always #10 clk = ~clk;

	// Watchdog, limit set once the vectors are loaded
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Timeout, run still busy after %0d cycles", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Vector file, fields split by | and one record per line
	////////////////////////////////////////////////////////////////////
	task automatic load_vectors(output int ok);
		int fd;
		int c;
		int field;
		int led_digits;
		int in_fill;
		int out_fill;
		logic [2:0] led_val;
		logic skip;
		logic blank;
		logic done;
		logic bad;
		ok = 0;
		in_fill = 0;
		out_fill = 0;
		bad = 0;
		done = 0;
		fd = $fopen("tests/forth_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file");
		end else begin
			field = 0;
			led_digits = 0;
			led_val = '0;
			skip = 0;
			blank = 1;
			in_start[0] = 0;
			out_start[0] = 0;
			while (!done) begin
				c = $fgetc(fd);
				// End of file closes the last line
				if (c == -1) begin
					done = 1;
					c = 8'h0a;
				end
				if (c == 8'h0a) begin
					if (!skip && !blank) begin
						if (field == 2 && led_digits == 3 && num_records < 64) begin
							in_len[num_records] = in_fill - in_start[num_records];
							out_len[num_records] = out_fill - out_start[num_records];
							led_exp[num_records] = led_val;
							num_records++;
						end else begin
							$display("Malformed record in the vector file");
							bad = 1;
						end
					end
					// Next record starts here
					in_start[num_records] = in_fill;
					out_start[num_records] = out_fill;
					field = 0;
					led_digits = 0;
					led_val = '0;
					skip = 0;
					blank = 1;
				end else if (blank && c == "#") begin
					skip = 1;
					blank = 0;
				end else if (!skip && c != 8'h0d) begin
					blank = 0;
					if (c == "|") begin
						field++;
					end else if (field == 0) begin
						in_buf[in_fill] = c[7:0];
						in_fill++;
					end else if (field == 1) begin
						out_buf[out_fill] = c[7:0];
						out_fill++;
					end else if (c == "0" || c == "1") begin
						// LED digits in r g b order
						led_val = {led_val[1:0], c == "1"};
						led_digits++;
					end
				end
			end
			$fclose(fd);
			if (num_records > 0 && !bad) begin
				ok = 1;
			end
			// 12 bit times per character plus quiet gaps and slack
			cycle_limit = (in_fill + num_records + out_fill) * 12 * CLKS_PER_BIT
				+ (num_records + 1) * 48 * CLKS_PER_BIT + 1000;
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Serial drive and decode
	////////////////////////////////////////////////////////////////////
	// 8N1 frame, LSB first, driven just after the rising edge
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		int n;
		frame = {1'b1, b, 1'b0};
		for (n = 0; n < 10; n++) begin
			@(posedge clk);
			#2;
			rx = frame[n];
			repeat (CLKS_PER_BIT - 1) @(posedge clk);
		end
	endtask

	// Line text then CR
	task automatic send_line(input int idx);
		int k;
		for (k = 0; k < in_len[idx]; k++) begin
			send_byte(in_buf[in_start[idx] + k]);
		end
		send_byte(8'h0d);
	endtask

	// Sampled on the falling edge, mid-bit
	task automatic receive_byte(output logic [7:0] b, output logic framed);
		int n;
		framed = 1;
		b = '0;
		@(negedge clk);
		while (tx !== 1'b0) begin
			@(negedge clk);
		end
		repeat (CLKS_PER_BIT / 2) @(negedge clk);
		if (tx !== 1'b0) begin
			framed = 0;
		end
		for (n = 0; n < 8; n++) begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			b[n] = tx;
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		if (tx !== 1'b1) begin
			framed = 0;
		end
	endtask

	task automatic check_text(input int idx);
		logic [7:0] got;
		logic [7:0] want;
		logic framed;
		int k;
		for (k = 0; k < out_len[idx]; k++) begin
			want = out_buf[out_start[idx] + k];
			receive_byte(got, framed);
			if (!framed) begin
				$display("Character %0d on tx has a bad start or stop bit", k + 1);
				error_count++;
			end
			if (got !== want) begin
				$display("Error at %0t ns: tx expected 8'h%02h got 8'h%02h", $time, want, got);
				error_count++;
			end
		end
	endtask

	// Line must stay high, any start bit is extra output
	task automatic watch_tx_idle(input int bits);
		int n;
		logic seen;
		seen = 0;
		for (n = 0; n < bits * CLKS_PER_BIT; n++) begin
			@(negedge clk);
			if (tx !== 1'b1) begin
				seen = 1;
			end
		end
		if (seen) begin
			$display("Unexpected output on tx while the line should be idle");
			error_count++;
		end
	endtask

	// want is {r, g, b}, 0 means on
	task automatic check_leds(input logic [2:0] want);
		if (led_r !== want[2]) begin
			$display("Error at %0t ns: led_r expected %b got %b", $time, want[2], led_r);
			error_count++;
		end
		if (led_g !== want[1]) begin
			$display("Error at %0t ns: led_g expected %b got %b", $time, want[1], led_g);
			error_count++;
		end
		if (led_b !== want[0]) begin
			$display("Error at %0t ns: led_b expected %b got %b", $time, want[0], led_b);
			error_count++;
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////
	task automatic report_test(input string name, input int errs_before);
		if (error_count == errs_before) begin
			tests_passed++;
			$display("Test \"%s\" passed", name);
		end else begin
			tests_failed++;
			$display("Test \"%s\" failed", name);
		end
	endtask

	task automatic run_record(input int idx);
		int errs_before;
		int k;
		string text;
		errs_before = error_count;
		text = "";
		for (k = 0; k < in_len[idx]; k++) begin
			text = $sformatf("%s%c", text, in_buf[in_start[idx] + k]);
		end
		// Output may start before the CR frame has ended
		fork
			send_line(idx);
			check_text(idx);
		join
		watch_tx_idle(40);
		check_leds(led_exp[idx]);
		report_test(text, errs_before);
	endtask

	initial begin
		int loaded;
		int i;
		int errs_before;
		clk = 1'b0;
		reset = 1'b0;
		rx = 1'b1;
		load_vectors(loaded);
		if (loaded == 0) begin
			$display("No usable records in the vector file");
			$display("STATUS: FAIL");
			$finish;
		end else begin
			repeat (4) @(posedge clk);
			#2;
			reset = 1'b1;
			// Idle line and LEDs off before any input
			errs_before = error_count;
			watch_tx_idle(4);
			check_leds(3'b111);
			report_test("reset idle", errs_before);
			for (i = 0; i < num_records; i++) begin
				run_record(i);
			end
			$display("Tests %0d, passed %0d, failed %0d, errors %0d",
				tests_passed + tests_failed, tests_passed, tests_failed, error_count);
			if (error_count == 0) begin
				$display("STATUS: PASS");
			end else begin
				$display("STATUS: FAIL");
			end
			$finish;
		end
	end

endmodule

// File: tests/forth_vectors.txt
# Columns: input line | text expected on tx | LEDs r g b after the line (0 is on)
# Every input line is sent with a CR after it
3 4 + .|7 |111
2 5 - .|-3 |111
5 led||001
2 led||110
zz|?|110
dupx|?|110
zz 1 .|?1 |110
4 dup + .|8 |110
0 0= neg .|1 |110
9 8 drp .|9 |110
65 emt|A|110

// File: sim.f
hdl/forth_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/boot_rom.sv
hdl/outer_interp.sv
hdl/inner_interp.sv
hdl/forth_core.sv
tests/forth_core_tb.sv
